// ==== flist.f ====
source/dmem_pkg.sv
source/dmem_access_if.sv
source/access_decode.sv
source/byte_lane.sv
source/lane_memory.sv
source/writeback_select.sv
source/data_memory_top.sv
sim/tb_data_memory.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_data_memory \
   -Mdir obj_dir -o tb_data_memory
./obj_dir/tb_data_memory | tee sim.log

if grep -q "^No errors$" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// ==== sim/tb_data_memory.sv ====
module tb_data_memory;
   import dmem_pkg::*;

   localparam int N_RAND        = 16;
   localparam int N_LOAD        = 8;
   localparam int N_PASS        = 6;
   // reset, then each test in order
   localparam int TEST_CYCLES   = 12 + 2 * N_RAND + 36 + 13 + (2 * N_LOAD + 5) + 7 + 3 * N_PASS;
   localparam int MARGIN_CYCLES = 50;

   logic     clk;
   logic     rst_n;
   logic     run;
   addr_t    addr;
   size_t    size;
   word_t    wdata;
   logic     we;
   logic     re;
   logic     mem_to_reg;
   word_t    alu_result;
   reg_idx_t rd_in;
   logic     reg_we_in;
   addr_t    load_addr;
   word_t    load_data;
   logic     load_we;
   word_t    reg_wdata;
   reg_idx_t reg_rd;
   logic     reg_we_out;
   word_t    uart_dout;
   logic     uart_we;

   logic [7:0]  model_mem [4096]; // byte image of the dut memory
   logic [31:0] lfsr_state = 32'h4552_a8c8;
   int          errors = 0;
   int          checks = 0;

   data_memory_top data_memory_top_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .run        (run),
      .addr       (addr),
      .size       (size),
      .wdata      (wdata),
      .we         (we),
      .re         (re),
      .mem_to_reg (mem_to_reg),
      .alu_result (alu_result),
      .rd_in      (rd_in),
      .reg_we_in  (reg_we_in),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .load_we    (load_we),
      .reg_wdata  (reg_wdata),
      .reg_rd     (reg_rd),
      .reg_we_out (reg_we_out),
      .uart_dout  (uart_dout),
      .uart_we    (uart_we)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      int          k;
      v = '0;
      for (k = 0; k < n; k++) begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         v          = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic void model_store(input addr_t a, input size_t s, input word_t d);
      int          nbytes;
      int          off;
      int          k;
      logic [11:0] ba;
      word_t       t;
      if (a == UART_TX_ADDR) return; // uart stores never reach memory
      nbytes = (s == SIZE_BYTE) ? 1 : (s == SIZE_HALF) ? 2 : 4;
      off    = int'(a[1:0]);
      for (k = 0; k < nbytes; k++) begin
         if (off + k < 4) begin // lanes past the word are dropped
            ba            = a[11:0] + 12'(k);
            t             = d >> (8 * k);
            model_mem[ba] = t[7:0];
         end
      end
   endfunction

   function automatic word_t model_load(input addr_t a, input size_t s);
      int          nbytes;
      int          off;
      int          k;
      logic [11:0] ba;
      word_t       w;
      if (a == UART_TX_ADDR) return '0;
      nbytes = (s == SIZE_BYTE) ? 1 : (s == SIZE_HALF) ? 2 : 4;
      off    = int'(a[1:0]);
      w      = '0;
      for (k = 0; k < nbytes; k++) begin
         if (off + k < 4) begin // bytes past the word read as zero
            ba          = a[11:0] + 12'(k);
            w[8*k +: 8] = model_mem[ba];
         end
      end
      return w;
   endfunction

   task automatic check_word(input word_t got, input word_t exp, input string what);
      checks++;
      assert (got === exp)
         else begin
            errors++;
            $display("[ERROR] %0t: %s, got %h expected %h", $time, what, got, exp);
         end
   endtask

   task automatic settle();
      @(posedge clk);
      #1;
   endtask

   task automatic store(input addr_t a, input size_t s, input word_t d);
      @(negedge clk);
      addr       = a;
      size       = s;
      wdata      = d;
      we         = 1'b1;
      re         = 1'b0;
      mem_to_reg = 1'b0;
      reg_we_in  = 1'b0;
      load_we    = 1'b0;
      model_store(a, s, d);
      settle();
   endtask

   task automatic load_check(input addr_t a, input size_t s, input string what);
      word_t exp;
      @(negedge clk);
      addr       = a;
      size       = s;
      we         = 1'b0;
      re         = 1'b1;
      mem_to_reg = 1'b1;
      alu_result = '0;
      rd_in      = 5'd1;
      reg_we_in  = 1'b1;
      load_we    = 1'b0;
      exp        = model_load(a, s);
      settle();
      check_word(reg_wdata, exp, $sformatf("%s at %h size %0d", what, a, s));
   endtask

   task automatic idle_cycle();
      @(negedge clk);
      we        = 1'b0;
      re        = 1'b0;
      reg_we_in = 1'b0;
      load_we   = 1'b0;
      settle();
   endtask

   task automatic loader_write(input addr_t a, input word_t d);
      int k;
      @(negedge clk);
      we        = 1'b0;
      re        = 1'b0;
      reg_we_in = 1'b0;
      load_addr = a;
      load_data = d;
      load_we   = 1'b1;
      for (k = 0; k < 4; k++) begin
         model_mem[{a[11:2], 2'b00} + 12'(k)] = d[8*k +: 8];
      end
      settle();
   endtask

   // core word store and loader write in the same cycle
   task automatic collide(input addr_t a, input word_t d, input addr_t la, input word_t ld);
      @(negedge clk);
      addr      = a;
      size      = SIZE_WORD;
      wdata     = d;
      we        = 1'b1;
      re        = 1'b0;
      reg_we_in = 1'b0;
      load_addr = la;
      load_data = ld;
      load_we   = 1'b1;
      model_store(a, SIZE_WORD, d); // loader data is dropped
      settle();
   endtask

   task automatic word_round_trip();
      addr_t       addrs [N_RAND];
      logic [31:0] r;
      int          i;
      for (i = 0; i < N_RAND; i++) begin
         r        = rand_bits(10);
         addrs[i] = {20'h0, r[9:0], 2'b00};
         store(addrs[i], SIZE_WORD, rand_bits(32));
      end
      for (i = 0; i < N_RAND; i++) begin
         load_check(addrs[i], SIZE_WORD, "word round trip");
      end
   endtask

   task automatic partial_stores();
      addr_t base;
      size_t s;
      int    si;
      int    off;
      for (si = 0; si < 3; si++) begin
         for (off = 0; off < 4; off++) begin
            s    = (si == 0) ? SIZE_BYTE : (si == 1) ? SIZE_HALF : SIZE_WORD;
            base = 32'h100 + 16 * si + 4 * off;
            store(base, SIZE_WORD, rand_bits(32)); // known background
            store(base + off, s, rand_bits(32));
            load_check(base, SIZE_WORD, "merged lanes");
         end
      end
   endtask

   task automatic narrow_loads();
      size_t s;
      int    si;
      int    off;
      store(32'h200, SIZE_WORD, rand_bits(32));
      for (si = 0; si < 3; si++) begin
         for (off = 0; off < 4; off++) begin
            s = (si == 0) ? SIZE_BYTE : (si == 1) ? SIZE_HALF : SIZE_WORD;
            load_check(32'h200 + off, s, "narrow load");
         end
      end
   endtask

   task automatic loader_port();
      int i;
      for (i = 0; i < N_LOAD; i++) begin
         loader_write(32'h300 + 4 * i, rand_bits(32));
      end
      for (i = 0; i < N_LOAD; i++) begin
         load_check(32'h300 + 4 * i, SIZE_WORD, "loader word");
      end
      store(32'h384, SIZE_WORD, rand_bits(32));
      collide(32'h380, rand_bits(32), 32'h380, rand_bits(32)); // same word
      collide(32'h380, rand_bits(32), 32'h384, rand_bits(32)); // other word
      load_check(32'h380, SIZE_WORD, "core store during loader write");
      load_check(32'h384, SIZE_WORD, "loader write during core store");
   endtask

   task automatic uart_store_and_load();
      word_t d;
      store(32'h0, SIZE_WORD, rand_bits(32)); // word 0 aliases the uart address
      d = rand_bits(32);
      store(UART_TX_ADDR, SIZE_WORD, d);
      check_word({31'b0, uart_we}, 32'd1, "uart_we on word store");
      check_word(uart_dout, d, "uart word data");
      idle_cycle();
      check_word({31'b0, uart_we}, 32'd0, "uart_we one cycle later");
      d = rand_bits(32);
      store(UART_TX_ADDR, SIZE_BYTE, d);
      check_word({31'b0, uart_we}, 32'd1, "uart_we on byte store");
      check_word(uart_dout, {24'h0, d[7:0]}, "uart byte data");
      idle_cycle();
      check_word({31'b0, uart_we}, 32'd0, "uart_we after byte store");
      load_check(32'h0, SIZE_WORD, "memory under uart address");
      load_check(UART_TX_ADDR, SIZE_WORD, "uart load");
   endtask

   task automatic passthrough_and_run();
      word_t       alu;
      logic [31:0] r;
      int          i;
      for (i = 0; i < N_PASS; i++) begin
         alu = rand_bits(32);
         r   = rand_bits(5);
         @(negedge clk);
         we         = 1'b0;
         re         = 1'b0;
         load_we    = 1'b0;
         mem_to_reg = 1'b0;
         alu_result = alu;
         rd_in      = r[4:0];
         reg_we_in  = 1'b1;
         run        = 1'b1;
         settle();
         check_word(reg_wdata, alu, "alu pass through");
         check_word({27'b0, reg_rd}, {27'b0, r[4:0]}, "rd pass through");
         check_word({31'b0, reg_we_out}, 32'd1, "reg_we_out with run high");
         @(negedge clk);
         run = 1'b0;
         settle();
         check_word({31'b0, reg_we_out}, 32'd0, "reg_we_out with run low");
         @(negedge clk);
         reg_we_in = 1'b0;
         settle();
         check_word({31'b0, reg_we_out}, 32'd0, "reg_we_out idle with run low");
      end
   endtask

   initial begin
      #((TEST_CYCLES + MARGIN_CYCLES) * 100);
      $display("watchdog: tests did not finish within %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
      $display("Errors found");
      $finish;
   end

   initial begin
      rst_n      = 1'b0;
      run        = 1'b1;
      addr       = UART_TX_ADDR; // uart store and register write held against reset
      size       = SIZE_WORD;
      wdata      = '0;
      we         = 1'b1;
      re         = 1'b0;
      mem_to_reg = 1'b0;
      alu_result = '0;
      rd_in      = '0;
      reg_we_in  = 1'b1;
      load_addr  = '0;
      load_data  = '0;
      load_we    = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      check_word({31'b0, reg_we_out}, 32'd0, "reg_we_out in reset");
      check_word({31'b0, uart_we}, 32'd0, "uart_we in reset");
      @(negedge clk);
      rst_n     = 1'b1;
      addr      = '0;
      we        = 1'b0;
      reg_we_in = 1'b0;

      word_round_trip();
      partial_stores();
      narrow_loads();
      loader_port();
      uart_store_and_load();
      passthrough_and_run();

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== source/access_decode.sv ====
module access_decode #(
   parameter int ADDR_BITS = 12
) (
   input  dmem_pkg::addr_t  addr,
   input  dmem_pkg::size_t  size,
   input  dmem_pkg::word_t  wdata,
   input  logic             we,
   dmem_access_if.decoder   acc
);
   import dmem_pkg::*;

   lane_mask_t base_mask;
   word_t      base_data;
   lane_mask_t lanes;
   word_t      store_data;
   byte_off_t  offset;
   logic       uart_hit;
   logic       mem_write;

   assign offset   = addr[1:0];
   assign uart_hit = (addr == UART_TX_ADDR);

   // mask and data before alignment
   always_comb begin
      case (size)
         SIZE_BYTE: begin
            base_mask = 4'b0001;
            base_data = {24'h0, wdata[7:0]};
         end
         SIZE_HALF: begin
            base_mask = 4'b0011;
            base_data = {16'h0, wdata[15:0]};
         end
         default: begin
            base_mask = 4'b1111;
            base_data = wdata;
         end
      endcase
   end

   always_comb begin
      // lanes shifted past bit 3 fall off
      lanes      = base_mask << offset;
      store_data = base_data << {offset, 3'b000};
      mem_write  = we && !uart_hit;
   end

   assign acc.word_index = addr[ADDR_BITS-1:2];
   assign acc.lanes      = lanes;
   assign acc.store_data = store_data;
   assign acc.mem_write  = mem_write;
   assign acc.uart_hit   = uart_hit;
   assign acc.offset     = offset;
   assign acc.size       = size;

endmodule

// ==== source/byte_lane.sv ====
module byte_lane #(
   parameter int ADDR_BITS = 12
) (
   input  logic                 clk,
   input  logic [ADDR_BITS-3:0] raddr,
   input  logic [ADDR_BITS-3:0] waddr,
   input  logic [7:0]           din,
   input  logic                 we,
   output logic [7:0]           dout
);

   localparam int DEPTH = 2 ** (ADDR_BITS - 2);

   logic [7:0] mem [DEPTH];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= din;
      end
   end

   assign dout = mem[raddr]; // async read

endmodule

// ==== source/data_memory_top.sv ====
module data_memory_top #(
   parameter int ADDR_BITS = 12
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                run,
   input  dmem_pkg::addr_t     addr,
   input  dmem_pkg::size_t     size,
   input  dmem_pkg::word_t     wdata,
   input  logic                we,
   input  logic                re,
   input  logic                mem_to_reg,
   input  dmem_pkg::word_t     alu_result,
   input  dmem_pkg::reg_idx_t  rd_in,
   input  logic                reg_we_in,
   input  dmem_pkg::addr_t     load_addr,
   input  dmem_pkg::word_t     load_data,
   input  logic                load_we,
   output dmem_pkg::word_t     reg_wdata,
   output dmem_pkg::reg_idx_t  reg_rd,
   output logic                reg_we_out,
   output dmem_pkg::word_t     uart_dout,
   output logic                uart_we
);
   import dmem_pkg::*;

   word_t read_word; // unshifted word at the access index

   dmem_access_if #(
      .ADDR_BITS (ADDR_BITS)
   ) acc_if ();

   access_decode #(
      .ADDR_BITS (ADDR_BITS)
   ) access_decode_i (
      .addr  (addr),
      .size  (size),
      .wdata (wdata),
      .we    (we),
      .acc   (acc_if.decoder)
   );

   lane_memory #(
      .ADDR_BITS (ADDR_BITS)
   ) lane_memory_i (
      .clk       (clk),
      .acc       (acc_if.memory),
      .load_addr (load_addr),
      .load_data (load_data),
      .load_we   (load_we),
      .read_word (read_word)
   );

   writeback_select writeback_select_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .acc        (acc_if.result),
      .read_word  (read_word),
      .run        (run),
      .we         (we),
      .re         (re),
      .mem_to_reg (mem_to_reg),
      .alu_result (alu_result),
      .rd_in      (rd_in),
      .reg_we_in  (reg_we_in),
      .reg_wdata  (reg_wdata),
      .reg_rd     (reg_rd),
      .reg_we_out (reg_we_out),
      .uart_dout  (uart_dout),
      .uart_we    (uart_we)
   );

endmodule

// ==== source/dmem_access_if.sv ====
interface dmem_access_if #(
   parameter int ADDR_BITS = 12
);
   import dmem_pkg::*;

   logic [ADDR_BITS-3:0] word_index;
   lane_mask_t           lanes;
   word_t                store_data;  // already on its lanes
   logic                 mem_write;   // strobe without uart hits
   logic                 uart_hit;
   byte_off_t            offset;
   size_t                size;

   modport decoder (
      output word_index, lanes, store_data, mem_write, uart_hit, offset, size
   );

   modport memory (
      input word_index, lanes, store_data, mem_write
   );

   modport result (
      input uart_hit, offset, size, store_data
   );

endinterface

// ==== source/dmem_pkg.sv ====
package dmem_pkg;

   typedef logic [31:0] addr_t;      // byte address
   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [1:0]  size_t;
   typedef logic [3:0]  lane_mask_t; // one bit per byte lane
   typedef logic [1:0]  byte_off_t;

   // access size codes, 3 behaves as word
   localparam size_t SIZE_WORD = 2'd0;
   localparam size_t SIZE_BYTE = 2'd1;
   localparam size_t SIZE_HALF = 2'd2;

   localparam addr_t UART_TX_ADDR = 32'h1000_0000; // tx register

endpackage

// ==== source/lane_memory.sv ====
module lane_memory #(
   parameter int ADDR_BITS = 12
) (
   input  logic             clk,
   dmem_access_if.memory    acc,
   input  dmem_pkg::addr_t  load_addr,
   input  dmem_pkg::word_t  load_data,
   input  logic             load_we,
   output dmem_pkg::word_t  read_word
);
   import dmem_pkg::*;

   logic [ADDR_BITS-3:0] waddr;
   word_t                wdata;
   lane_mask_t           lane_we;
   word_t                lane_bits; // lanes spread to bit enables

   // core write wins, loader only fills idle cycles
   always_comb begin
      if (acc.mem_write) begin
         waddr   = acc.word_index;
         wdata   = acc.store_data;
         lane_we = acc.lanes;
      end else begin
         waddr   = load_addr[ADDR_BITS-1:2];
         wdata   = load_data;
         lane_we = load_we ? 4'b1111 : 4'b0000;
      end
   end

   for (genvar i = 0; i < 4; i++) begin : g_lane
      byte_lane #(
         .ADDR_BITS (ADDR_BITS)
      ) byte_lane_i (
         .clk   (clk),
         .raddr (acc.word_index),
         .waddr (waddr),
         .din   (wdata[8*i +: 8]),
         .we    (lane_we[i]),
         .dout  (read_word[8*i +: 8])
      );

      assign lane_bits[8*i +: 8] = {8{acc.lanes[i]}};
   end

   // after a collision the word holds the core data on its lanes
   a_core_over_loader : assert property (
      @(posedge clk)
      (load_we && acc.mem_write) |=>
         (acc.word_index != $past(acc.word_index) ||
          (read_word & $past(lane_bits)) == ($past(acc.store_data) & $past(lane_bits)))
   ) else $error("loader write applied during core write");

endmodule

// ==== source/writeback_select.sv ====
module writeback_select (
   input  logic                clk,
   input  logic                rst_n,
   dmem_access_if.result       acc,
   input  dmem_pkg::word_t     read_word,
   input  logic                run,
   input  logic                we,
   input  logic                re,  // not needed, reads are always on
   input  logic                mem_to_reg,
   input  dmem_pkg::word_t     alu_result,
   input  dmem_pkg::reg_idx_t  rd_in,
   input  logic                reg_we_in,
   output dmem_pkg::word_t     reg_wdata,
   output dmem_pkg::reg_idx_t  reg_rd,
   output logic                reg_we_out,
   output dmem_pkg::word_t     uart_dout,
   output logic                uart_we
);
   import dmem_pkg::*;

   word_t shifted;
   word_t load_value;
   logic  uart_store;

   // memory is read every cycle, so the value does not depend on re;
   // mem_to_reg alone picks load data over the alu result
   assign shifted = read_word >> {acc.offset, 3'b000};

   always_comb begin
      if (acc.uart_hit) begin
         load_value = '0;
      end else begin
         case (acc.size)
            SIZE_BYTE: load_value = {24'h0, shifted[7:0]};
            SIZE_HALF: load_value = {16'h0, shifted[15:0]};
            default:   load_value = shifted;
         endcase
      end
   end

   assign uart_store = we && acc.uart_hit;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         reg_we_out <= 1'b0;
         uart_we    <= 1'b0;
      end else begin
         reg_we_out <= reg_we_in && run;
         uart_we    <= uart_store;
      end
   end

   always_ff @(posedge clk) begin
      reg_wdata <= mem_to_reg ? load_value : alu_result;
      reg_rd    <= rd_in;
      if (uart_store) begin
         uart_dout <= acc.store_data;
      end
   end

   // back to back pulses need back to back stores
   a_uart_pulse : assert property (
      @(posedge clk) disable iff (!rst_n)
      (uart_we && $past(uart_we)) |-> ($past(we) && $past(we, 2))
   ) else $error("uart_we held without consecutive stores");

endmodule
